// File: logic/fir_pkg.sv
// shared widths, types and coefficient tables for the filter bank
package fir_pkg;

	// widths with a meaning of their own
	localparam int SAMPLE_W = 16;
	localparam int COEF_W = 8;
	localparam int ACC_W = 28;
	localparam int CHAN_W = 2;

	// kernel shape and channel count
	localparam int NUM_TAPS = 7;
	localparam int NUM_CHAN = 3;

	// unsigned pixel sample from the row stream
	typedef logic [SAMPLE_W-1:0] sample_t;

	// coefficient magnitude, signs are not kept
	typedef logic [COEF_W-1:0] coef_t;

	// widest set weight is 673 so 26 bits would do
	typedef logic [ACC_W-1:0] acc_t;

	// channel tag carried with every result
	typedef logic [CHAN_W-1:0] chan_t;

	// coefficient rows, indexed by channel then tap
	// tap 0 weights the newest sample
	localparam coef_t COEF_SETS [NUM_CHAN][NUM_TAPS] = '{
		// smoothing
		'{8'd4, 8'd42, 8'd163, 8'd255, 8'd163, 8'd42, 8'd4},
		// wide derivative magnitude
		'{8'd15, 8'd25, 8'd193, 8'd0, 8'd193, 8'd25, 8'd15},
		// narrow derivative magnitude
		'{8'd9, 8'd56, 8'd109, 8'd0, 8'd109, 8'd56, 8'd9}
	};

	// one filter result on the shared bus
	typedef struct packed {
		chan_t chan;
		acc_t  sum;
	} fir_result_t;

	// output stage of the arbiter
	// IDLE is empty, HOLD has a result waiting for out_ready
	typedef enum logic [0:0] {
		IDLE,
		HOLD
	} arb_state_t;

endpackage

// File: logic/fir_tap_filter.sv
`timescale 1ns/1ps

// one seven-tap symmetric FIR channel with a single result slot
module fir_tap_filter #(
	parameter fir_pkg::chan_t CHAN = 2'd0
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                sample_valid,
	input  fir_pkg::sample_t    sample,
	input  logic                res_ready,
	output logic                res_valid,
	output fir_pkg::fir_result_t res
);

	// six stored samples, delay_q[0] is the most recent one
	fir_pkg::sample_t delay_q [fir_pkg::NUM_TAPS-1];

	// tap window seen by the multipliers
	// taps[0] is the sample arriving this cycle
	fir_pkg::sample_t taps [fir_pkg::NUM_TAPS];

	// weighted sum over the current window
	fir_pkg::acc_t sum_next;

	// stored result of the slot
	fir_pkg::acc_t sum_q;

	// slot drains on the grant edge
	logic res_take;

	assign res_take = res_valid && res_ready;

	// window is the incoming sample followed by the delay line
	always_comb
	begin
		taps[0] = sample;
		for (int i = 1; i < fir_pkg::NUM_TAPS; i++)
		begin
			taps[i] = delay_q[i-1];
		end
	end

	// multiply-accumulate over all seven taps
	// zero weights simply add nothing
	always_comb
	begin
		sum_next = '0;
		for (int i = 0; i < fir_pkg::NUM_TAPS; i++)
		begin
			sum_next = sum_next
				+ fir_pkg::acc_t'(taps[i])
				* fir_pkg::acc_t'(fir_pkg::COEF_SETS[CHAN][i]);
		end
	end

	// delay line shifts once per accepted sample
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < fir_pkg::NUM_TAPS-1; i++)
			begin
				delay_q[i] <= '0;
			end
		end
		else if (sample_valid)
		begin
			delay_q[0] <= sample;
			for (int i = 1; i < fir_pkg::NUM_TAPS-1; i++)
			begin
				delay_q[i] <= delay_q[i-1];
			end
		end
	end

	// slot occupancy
	// the top level only sends a sample while every slot is empty
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			res_valid <= 1'b0;
		end
		else if (sample_valid)
		begin
			res_valid <= 1'b1;
		end
		else if (res_take)
		begin
			res_valid <= 1'b0;
		end
	end

	// sum is captured on the same edge as the shift
	always_ff @(posedge clk)
	begin
		if (sample_valid)
		begin
			sum_q <= sum_next;
		end
	end

	// result leaves tagged with this channel
	always_comb
	begin
		res.chan = CHAN;
		res.sum = sum_q;
	end

endmodule

// File: logic/result_arbiter.sv
`timescale 1ns/1ps

// round-robin merge of the channel results onto one output bus
module result_arbiter (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic [fir_pkg::NUM_CHAN-1:0]               req_valid,
	input  fir_pkg::fir_result_t [fir_pkg::NUM_CHAN-1:0] req,
	input  logic                                       out_ready,
	output logic [fir_pkg::NUM_CHAN-1:0]               grant,
	output logic                                       out_valid,
	output fir_pkg::fir_result_t                       out_result
);

	// output stage state
	fir_pkg::arb_state_t state_q;
	fir_pkg::arb_state_t state_next;

	// last channel that won a grant
	fir_pkg::chan_t last_q;

	// winner of this cycle
	fir_pkg::chan_t pick;
	logic           pick_found;

	// stage can take a new result this cycle
	logic can_load;

	// stage is empty or drains on this edge
	assign can_load = (state_q == fir_pkg::IDLE) || out_ready;

	// search starts one past the last winner and wraps around
	always_comb
	begin
		int idx;

		pick = last_q;
		pick_found = 1'b0;
		idx = 0;
		for (int k = 1; k <= fir_pkg::NUM_CHAN; k++)
		begin
			idx = (int'(last_q) + k) % fir_pkg::NUM_CHAN;
			if (!pick_found && req_valid[idx])
			begin
				pick_found = 1'b1;
				pick = fir_pkg::chan_t'(idx);
			end
		end
	end

	// grant doubles as the ready of the chosen channel
	always_comb
	begin
		grant = '0;
		if (can_load && pick_found)
		begin
			grant[pick] = 1'b1;
		end
	end

	// next state of the output stage
	always_comb
	begin
		state_next = state_q;
		case (state_q)
			fir_pkg::IDLE:
			begin
				if (pick_found)
				begin
					state_next = fir_pkg::HOLD;
				end
			end
			fir_pkg::HOLD:
			begin
				// refill on the drain edge keeps the bus busy
				if (out_ready && !pick_found)
				begin
					state_next = fir_pkg::IDLE;
				end
			end
			default:
			begin
				state_next = fir_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_q <= fir_pkg::IDLE;
		end
		else
		begin
			state_q <= state_next;
		end
	end

	// after reset channel 0 comes first
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			last_q <= fir_pkg::chan_t'(fir_pkg::NUM_CHAN - 1);
		end
		else if (can_load && pick_found)
		begin
			last_q <= pick;
		end
	end

	// registered output data
	// only loads on a grant, so it holds while out_ready is low
	always_ff @(posedge clk)
	begin
		if (can_load && pick_found)
		begin
			out_result <= req[pick];
		end
	end

	assign out_valid = (state_q == fir_pkg::HOLD);

endmodule

// File: logic/fir_bank.sv
`timescale 1ns/1ps

// three-channel row filter bank sharing one result bus
module fir_bank (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  fir_pkg::sample_t     in_sample,
	input  logic                 out_ready,
	output logic                 in_ready,
	output logic                 out_valid,
	output fir_pkg::fir_result_t out_result
);

	// per-channel result slots
	logic [fir_pkg::NUM_CHAN-1:0]                 res_valid;
	fir_pkg::fir_result_t [fir_pkg::NUM_CHAN-1:0] res;

	// per-channel grant from the arbiter
	logic [fir_pkg::NUM_CHAN-1:0] grant;

	// sample taken on this edge by every channel
	logic sample_accept;

	// accept only when every slot is empty
	// so all channels see the same samples in lockstep
	assign in_ready = ~|res_valid;

	assign sample_accept = in_valid && in_ready;

	// one filter per coefficient set
	for (genvar g = 0; g < fir_pkg::NUM_CHAN; g++)
	begin : gen_chan
		fir_tap_filter #(
			.CHAN(fir_pkg::chan_t'(g))
		) fir_tap_filter_inst (
			.clk         (clk),
			.rst_n       (rst_n),
			.sample_valid(sample_accept),
			.sample      (in_sample),
			.res_ready   (grant[g]),
			.res_valid   (res_valid[g]),
			.res         (res[g])
		);
	end

	// merge the three slots onto the output bus
	result_arbiter result_arbiter_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (res_valid),
		.req       (res),
		.out_ready (out_ready),
		.grant     (grant),
		.out_valid (out_valid),
		.out_result(out_result)
	);

endmodule

// File: sim/fir_bank_props.sv
`timescale 1ns/1ps

// protocol checks on the output arbiter of the filter bank
module fir_bank_props (
	input logic                                 clk,
	input logic                                 rst_n,
	input logic [fir_pkg::NUM_CHAN-1:0]         req_valid,
	input logic [fir_pkg::NUM_CHAN-1:0]         grant,
	input logic                                 out_ready,
	input logic                                 out_valid,
	input fir_pkg::fir_result_t                 out_result
);

	// number of assertion failures seen so far
	int assert_failures = 0;

	// a stalled result must not change under the consumer
	result_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> $stable(out_result)
	) else
	begin
		$error("out_result changed while waiting for out_ready");
		assert_failures++;
	end

	// at most one channel drained per cycle
	grant_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(grant)
	) else
	begin
		$error("more than one grant in a cycle");
		assert_failures++;
	end

	grant_to_requester: assert property (
		@(posedge clk) disable iff (!rst_n)
		(grant & ~req_valid) == '0
	) else
	begin
		$error("grant given to a channel with no result");
		assert_failures++;
	end

	// stage is empty right after a reset edge
	empty_after_reset: assert property (
		@(posedge clk)
		!rst_n |=> !out_valid
	) else
	begin
		$error("out_valid high in the cycle after reset");
		assert_failures++;
	end

endmodule

bind result_arbiter fir_bank_props fir_bank_props_inst (
	.clk       (clk),
	.rst_n     (rst_n),
	.req_valid (req_valid),
	.grant     (grant),
	.out_ready (out_ready),
	.out_valid (out_valid),
	.out_result(out_result)
);

// File: sim/fir_bank_tb.sv
`timescale 1ns/1ps

module fir_bank_tb;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_SAMPLES = 60;
	localparam int DRAIN_LIMIT = 40;
	// two long tests plus the single sample of the fairness test
	localparam int SAMPLES_SENT = 2 * NUM_SAMPLES + 1;
	localparam int WATCHDOG_CYCLES = 40 * SAMPLES_SENT + 200;

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic                 in_valid;
	fir_pkg::sample_t     in_sample;
	logic                 out_ready;
	logic                 in_ready;
	logic                 out_valid;
	fir_pkg::fir_result_t out_result;

	logic [31:0] lfsr_state = 32'he591_62b3;
	logic        random_ready;

	// model delay lines with index 0 the newest sample
	fir_pkg::sample_t model_line [fir_pkg::NUM_CHAN][fir_pkg::NUM_TAPS];
	fir_pkg::acc_t    exp_q [fir_pkg::NUM_CHAN][$];
	int               exp_chan;

	string cur_test;
	int    pass_count = 0;
	int    fail_count = 0;
	int    fail_at_start;
	int    accepted_count;
	int    result_count;

	fir_bank fir_bank_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_sample (in_sample),
		.out_ready (out_ready),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_result(out_result)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// right-shift Galois form stepped once per call
	function automatic logic lfsr_bit();
		logic bit_out;
		bit_out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (bit_out)
		begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return bit_out;
	endfunction

	function automatic fir_pkg::sample_t random_sample();
		fir_pkg::sample_t s;
		s = '0;
		for (int i = 0; i < 16; i++)
		begin
			s = {s[14:0], lfsr_bit()};
		end
		return s;
	endfunction

	function automatic int pending_results();
		int n;
		n = 0;
		for (int c = 0; c < fir_pkg::NUM_CHAN; c++)
		begin
			n += exp_q[c].size();
		end
		return n;
	endfunction

	task automatic check_value(input string what, input longint exp, input longint got);
		assert (exp == got)
		begin
			pass_count++;
		end
		else
		begin
			$display("CHECK FAILED %s: %s expected %0d actual %0d", cur_test, what, exp, got);
			fail_count++;
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond)
		begin
			pass_count++;
		end
		else
		begin
			$display("ERROR in %s: %s", cur_test, msg);
			fail_count++;
		end
	endtask

	// every channel sees the same sample, weighted by its own row
	task automatic model_accept(input fir_pkg::sample_t s);
		longint total;
		for (int c = 0; c < fir_pkg::NUM_CHAN; c++)
		begin
			for (int i = fir_pkg::NUM_TAPS - 1; i > 0; i--)
			begin
				model_line[c][i] = model_line[c][i-1];
			end
			model_line[c][0] = s;
			total = 0;
			for (int i = 0; i < fir_pkg::NUM_TAPS; i++)
			begin
				total += longint'(model_line[c][i]) * longint'(fir_pkg::COEF_SETS[c][i]);
			end
			exp_q[c].push_back(fir_pkg::acc_t'(total));
		end
		accepted_count++;
	endtask

	task automatic check_result(input fir_pkg::fir_result_t r);
		int c;
		c = int'(r.chan);
		result_count++;
		// all three slots fill together, so the order is always 0 1 2
		check_value("channel order", exp_chan, c);
		check_true(c < fir_pkg::NUM_CHAN, "result tagged with an unknown channel");
		if (c < fir_pkg::NUM_CHAN)
		begin
			check_true(exp_q[c].size() > 0, "result arrived with no sample pending");
			if (exp_q[c].size() > 0)
			begin
				check_value("sum", exp_q[c].pop_front(), r.sum);
			end
			exp_chan = (c + 1) % fir_pkg::NUM_CHAN;
		end
	endtask

	// both transfers are judged half a cycle before their edge
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (in_valid && in_ready)
			begin
				model_accept(in_sample);
			end
			if (out_valid && out_ready)
			begin
				check_result(out_result);
			end
		end
	end

	task automatic apply_reset();
		rst_n = 1'b0;
		in_valid = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int c = 0; c < fir_pkg::NUM_CHAN; c++)
		begin
			exp_q[c].delete();
			for (int i = 0; i < fir_pkg::NUM_TAPS; i++)
			begin
				model_line[c][i] = '0;
			end
		end
		exp_chan = 0;
	endtask

	// caller is 1 ns after a rising edge
	task automatic send_sample(input fir_pkg::sample_t s);
		logic taken;
		in_valid = 1'b1;
		in_sample = s;
		taken = 1'b0;
		while (!taken)
		begin
			if (random_ready)
			begin
				out_ready = lfsr_bit();
			end
			@(negedge clk);
			taken = in_ready;
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
	endtask

	task automatic drain_results();
		int waited;
		out_ready = 1'b1;
		waited = 0;
		while (pending_results() != 0 && waited < DRAIN_LIMIT)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		check_true(pending_results() == 0, "results still missing after the drain limit");
		// a duplicate would still show up in the monitor here
		repeat (5) @(posedge clk);
		#1;
		check_value("out_valid after drain", 0, out_valid);
		check_value("in_ready after drain", 1, in_ready);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		fail_at_start = fail_count;
		accepted_count = 0;
		result_count = 0;
	endtask

	task automatic end_test();
		check_value("results per accepted sample", 3 * accepted_count, result_count);
		$display("test %s finished with %0d errors", cur_test, fail_count - fail_at_start);
	endtask

	initial
	begin
		in_valid = 1'b0;
		in_sample = '0;
		out_ready = 1'b1;
		random_ready = 1'b0;
		cur_test = "reset";
		apply_reset();

		start_test("reset state");
		check_value("out_valid", 0, out_valid);
		check_value("in_ready", 1, in_ready);
		end_test();

		start_test("filter values and order");
		repeat (NUM_SAMPLES) send_sample(random_sample());
		drain_results();
		end_test();

		start_test("back-pressure");
		random_ready = 1'b1;
		repeat (NUM_SAMPLES) send_sample(random_sample());
		random_ready = 1'b0;
		drain_results();
		end_test();

		apply_reset();
		start_test("round-robin after reset");
		send_sample(random_sample());
		drain_results();
		end_test();

		// failures of the bound protocol assertions count against the run
		fail_count += fir_bank_inst.result_arbiter_inst.fir_bank_props_inst.assert_failures;

		$display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
		begin
			$display("Test passed");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

// File: list.f
logic/fir_pkg.sv
logic/fir_tap_filter.sv
logic/result_arbiter.sv
logic/fir_bank.sv
sim/fir_bank_props.sv
sim/fir_bank_tb.sv

// File: run.sh
#!/bin/sh
# build the filter bank testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module fir_bank_tb --Mdir obj_dir -o fir_bank_sim -f list.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/fir_bank_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$log"; then
	exit 1
fi

if ! grep -q "Test passed" "$log"; then
	echo "no final verdict found in $log"
	exit 1
fi

exit 0
